//--- Bender.yml
package:
  name: multiplication_unit

sources:
  # RTL in compile order
  - mul_pkg.sv
  - mul_operand_conditioner.sv
  - mul_array_stage.sv
  - mul_result_converter.sv
  - multiplication_unit.sv
  # Verification only
  - target: simulation
    files:
      - multiplication_unit_sva.sv
      - tb_multiplication_unit.sv

//--- mul_array_stage.sv
// One stage of the long-multiplication array.
// Looks at its own slice of multiplier bits and, for every set bit,
// adds the multiplicand shifted to that bit's weight into the running
// sum. The updated stage struct is registered for the next stage.

`timescale 1ns/1ps
`default_nettype none

module mul_array_stage #(
    // Position of this stage in the chain, picks the multiplier slice
    parameter int unsigned STAGE_IDX = 0
) (
    input  wire logic          clk_i,
    input  wire logic          rst_n_i,
    input  wire logic          clk_en_i,
    input  mul_pkg::mul_stage_t stage_i,
    output mul_pkg::mul_stage_t stage_o
);

    mul_pkg::mul_stage_t stage_d;
    mul_pkg::mul_stage_t stage_q;

    // ----------------------------------------
    // Partial product accumulation
    // ----------------------------------------

    always_comb begin : accumulate
        // Control and operands pass through untouched
        stage_d = stage_i;

        // Slice covers bits STAGE_IDX*BITS_PER_STAGE upwards
        for (int unsigned bit_idx = 0; bit_idx < mul_pkg::BITS_PER_STAGE; bit_idx++) begin
            if (stage_i.multiplier[STAGE_IDX * mul_pkg::BITS_PER_STAGE + bit_idx]) begin
                // Widen first so the shifted multiplicand keeps its upper bits
                stage_d.partial = stage_d.partial +
                    (mul_pkg::dword_t'(stage_i.multiplicand) <<
                     (STAGE_IDX * mul_pkg::BITS_PER_STAGE + bit_idx));
            end
        end
    end : accumulate

    // ----------------------------------------
    // Stage register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin : stage_reg
        if (!rst_n_i) begin
            stage_q.valid <= 1'b0;
        end else if (clk_en_i) begin
            stage_q <= stage_d;
        end
    end : stage_reg

    assign stage_o = stage_q;

endmodule : mul_array_stage

`default_nettype wire

//--- mul_operand_conditioner.sv
// First pipeline stage of the multiply unit.
// Turns operands that are negative and treated as signed into their
// magnitudes, works out the sign of the final result and registers the
// lot as the stage struct that enters the array, with a cleared sum.

`timescale 1ns/1ps
`default_nettype none

module mul_operand_conditioner (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,
    input  wire logic                    clk_en_i,
    input  wire logic                    data_valid_i,
    input  mul_pkg::mul_operation_t      operation_i,
    input  mul_pkg::word_t               multiplicand_i,
    input  mul_pkg::word_t               multiplier_i,
    output mul_pkg::mul_stage_t          stage_o
);

    // ----------------------------------------
    // Sign handling
    // ----------------------------------------

    logic multiplicand_signed;
    logic multiplier_signed;
    logic multiplicand_neg;
    logic multiplier_neg;

    // The multiplicand (rs1) is signed for everything except MULHU
    assign multiplicand_signed = (operation_i != mul_pkg::MULHU);

    // The multiplier (rs2) is signed only for MUL and MULH
    assign multiplier_signed = (operation_i == mul_pkg::MUL) ||
                               (operation_i == mul_pkg::MULH);

    // An operand only counts as negative if its sign bit is set and the
    // operation actually reads it as signed
    assign multiplicand_neg = multiplicand_i[mul_pkg::XLEN-1] & multiplicand_signed;
    assign multiplier_neg   = multiplier_i[mul_pkg::XLEN-1] & multiplier_signed;

    // ----------------------------------------
    // Next stage contents
    // ----------------------------------------

    mul_pkg::mul_stage_t stage_d;
    mul_pkg::mul_stage_t stage_q;

    always_comb begin : build_stage
        stage_d.valid     = data_valid_i;
        stage_d.operation = operation_i;
        // Product is negative when exactly one converted operand was negative
        stage_d.negate    = multiplicand_neg ^ multiplier_neg;
        // Two's complement magnitude for the converted operands
        stage_d.multiplicand = multiplicand_neg ? (~multiplicand_i + 1'b1) : multiplicand_i;
        stage_d.multiplier   = multiplier_neg   ? (~multiplier_i + 1'b1)   : multiplier_i;
        // The array starts accumulating from zero
        stage_d.partial = '0;
    end : build_stage

    // Stage register with the valid bit cleared on reset
    always_ff @(posedge clk_i) begin : stage_reg
        if (!rst_n_i) begin
            stage_q.valid <= 1'b0;
        end else if (clk_en_i) begin
            stage_q <= stage_d;
        end
    end : stage_reg

    assign stage_o = stage_q;

endmodule : mul_operand_conditioner

`default_nettype wire

//--- mul_pkg.sv
// Shared definitions for the pipelined RV32 multiply unit.
// Holds the width and depth constants, the operation encoding and the
// struct that every pipeline stage hands to the next one.
// Modules refer to these items by scoped name.

`default_nettype none

package mul_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Operand and result word width
    localparam int unsigned XLEN = 32;

    // Number of long-multiplication stages in the array
    localparam int unsigned MUL_STAGES = 8;

    // Each stage consumes an equal slice of the multiplier
    localparam int unsigned BITS_PER_STAGE = XLEN / MUL_STAGES;

    // One cycle for operand conditioning, one per array stage and one
    // for the final sign correction and word select
    localparam int unsigned MUL_LATENCY = MUL_STAGES + 2;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [2*XLEN-1:0] dword_t;

    // The four M-extension multiply flavours
    typedef enum logic [1:0] {
        MUL    = 2'b00,
        MULH   = 2'b01,
        MULHSU = 2'b10,
        MULHU  = 2'b11
    } mul_operation_t;

    // Everything that travels down the pipeline with one operand pair.
    // The operands are magnitudes, negate says whether the final sum
    // must be turned back into a negative number
    typedef struct packed {
        logic           valid;
        mul_operation_t operation;
        logic           negate;
        word_t          multiplicand;
        word_t          multiplier;
        dword_t         partial;
    } mul_stage_t;

endpackage

`default_nettype wire

//--- mul_result_converter.sv
// Last pipeline stage of the multiply unit.
// Restores the sign of the magnitude product coming out of the array and
// registers either the low word (MUL) or the high word (MULH, MULHSU,
// MULHU) together with the valid strobe.

`timescale 1ns/1ps
`default_nettype none

module mul_result_converter (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           clk_en_i,
    input  mul_pkg::mul_stage_t stage_i,
    output mul_pkg::word_t      product_o,
    output logic                data_valid_o
);

    mul_pkg::dword_t signed_product;
    mul_pkg::word_t  product_d;
    mul_pkg::word_t  product_q;
    logic            valid_q;

    // Two's complement of the full 64-bit sum when the signs differed
    assign signed_product = stage_i.negate ? (~stage_i.partial + 1'b1) : stage_i.partial;

    // MUL wants the low half, every other flavour returns the upper half
    always_comb begin : word_select
        if (stage_i.operation == mul_pkg::MUL) begin
            product_d = signed_product[mul_pkg::XLEN-1:0];
        end else begin
            product_d = signed_product[2*mul_pkg::XLEN-1:mul_pkg::XLEN];
        end
    end : word_select

    // ----------------------------------------
    // Output register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin : output_reg
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (clk_en_i) begin
            valid_q <= stage_i.valid;
        end
    end : output_reg

    // The product word loads on every enabled edge
    always_ff @(posedge clk_i) begin : product_reg
        if (clk_en_i) begin
            product_q <= product_d;
        end
    end : product_reg

    assign product_o    = product_q;
    assign data_valid_o = valid_q;

endmodule : mul_result_converter

`default_nettype wire

//--- multiplication_unit.sv
// Top level of the pipelined RV32 multiply unit.
// Accepts one operand pair per enabled cycle and returns the MUL, MULH,
// MULHSU or MULHU result MUL_LATENCY enabled cycles later. Dropping
// clk_en_i freezes the whole pipeline, there is no other stall.

`timescale 1ns/1ps
`default_nettype none

module multiplication_unit (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                clk_en_i,
    input  wire logic                data_valid_i,
    input  mul_pkg::mul_operation_t  operation_i,
    input  mul_pkg::word_t           multiplicand_i,
    input  mul_pkg::word_t           multiplier_i,
    output mul_pkg::word_t           product_o,
    output logic                     data_valid_o
);

    // Entry 0 comes from the conditioner, entry k+1 leaves array stage k,
    // the last entry feeds the converter
    mul_pkg::mul_stage_t stage_chain [mul_pkg::MUL_STAGES+1];

    // ----------------------------------------
    // Operand conditioning
    // ----------------------------------------

    mul_operand_conditioner i_conditioner (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .clk_en_i       ( clk_en_i       ),
        .data_valid_i   ( data_valid_i   ),
        .operation_i    ( operation_i    ),
        .multiplicand_i ( multiplicand_i ),
        .multiplier_i   ( multiplier_i   ),
        .stage_o        ( stage_chain[0] )
    );

    // ----------------------------------------
    // Long-multiplication array
    // ----------------------------------------

    for (genvar k = 0; k < mul_pkg::MUL_STAGES; k++) begin : g_array
        mul_array_stage #(
            .STAGE_IDX ( k )
        ) i_stage (
            .clk_i    ( clk_i            ),
            .rst_n_i  ( rst_n_i          ),
            .clk_en_i ( clk_en_i         ),
            .stage_i  ( stage_chain[k]   ),
            .stage_o  ( stage_chain[k+1] )
        );
    end : g_array

    // ----------------------------------------
    // Sign restore and word select
    // ----------------------------------------

    mul_result_converter i_converter (
        .clk_i        ( clk_i                           ),
        .rst_n_i      ( rst_n_i                         ),
        .clk_en_i     ( clk_en_i                        ),
        .stage_i      ( stage_chain[mul_pkg::MUL_STAGES] ),
        .product_o    ( product_o                       ),
        .data_valid_o ( data_valid_o                    )
    );

endmodule : multiplication_unit

`default_nettype wire

//--- multiplication_unit_sva.sv
// Concurrent checks on the valid strobe and stall behavior of the
// multiply unit. Bound into every multiplication_unit instance below.

`timescale 1ns/1ps
`default_nettype none

module multiplication_unit_sva (
    input wire logic           clk_i,
    input wire logic           rst_n_i,
    input wire logic           clk_en_i,
    input wire logic           data_valid_i,
    input wire mul_pkg::word_t product_o,
    input wire logic           data_valid_o
);

    // A reset edge leaves the output strobe low
    a_reset_clears_valid : assert property (@(posedge clk_i) !rst_n_i |=> !data_valid_o)
        else $error("data_valid_o high after a reset edge");

    // With the enable held, the strobe is the input strobe delayed by the full pipe
    a_valid_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        clk_en_i [*mul_pkg::MUL_LATENCY] |=>
            (data_valid_o == $past(data_valid_i, mul_pkg::MUL_LATENCY)))
        else $error("data_valid_o does not follow data_valid_i by MUL_LATENCY cycles");

    // A disabled edge must not move the strobe
    a_stall_holds_valid : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !clk_en_i |=> $stable(data_valid_o))
        else $error("data_valid_o changed while clk_en_i was low");

    // A disabled edge must not move the product word either
    a_stall_holds_product : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !clk_en_i |=> $stable(product_o))
        else $error("product_o changed while clk_en_i was low");

endmodule : multiplication_unit_sva

bind multiplication_unit multiplication_unit_sva i_sva (.*);

`default_nettype wire

//--- src.f
mul_pkg.sv
mul_operand_conditioner.sv
mul_array_stage.sv
mul_result_converter.sv
multiplication_unit.sv
multiplication_unit_sva.sv
tb_multiplication_unit.sv

//--- tb_multiplication_unit.sv
// Testbench for the pipelined RV32 multiply unit.
// Runs a fixed table of corner cases back to back, then random operand
// pairs with random clock-enable stalls. Every result is checked against
// a 64-bit reference product and against its expected enabled-edge latency.

`timescale 1ns/1ps
`default_nettype none

module tb_multiplication_unit;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TABLE    = 20;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_STALL    = 3;
    // Worst case every vector waits MAX_STALL disabled cycles, plus drain and margin
    localparam int TIMEOUT_NS = ((NUM_TABLE + NUM_RANDOM) * (1 + MAX_STALL) +
                                 mul_pkg::MUL_LATENCY + 20 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        mul_pkg::mul_operation_t operation;
        mul_pkg::word_t          multiplicand;
        mul_pkg::word_t          multiplier;
        mul_pkg::word_t          product;
    } vector_t;

    // One result still in flight and the enabled edge that sampled its operands
    typedef struct packed {
        mul_pkg::word_t product;
        int             edge_idx;
    } pending_t;

    logic                    clk_i = 1'b0;
    logic                    rst_n_i;
    logic                    clk_en_i;
    logic                    data_valid_i;
    mul_pkg::mul_operation_t operation_i;
    mul_pkg::word_t          multiplicand_i;
    mul_pkg::word_t          multiplier_i;
    mul_pkg::word_t          product_o;
    logic                    data_valid_o;

    vector_t  vector_table [NUM_TABLE];
    pending_t pending [$];
    int       enabled_edges     = 0;
    logic     last_edge_enabled = 1'b0;

    multiplication_unit i_dut (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .clk_en_i       ( clk_en_i       ),
        .data_valid_i   ( data_valid_i   ),
        .operation_i    ( operation_i    ),
        .multiplicand_i ( multiplicand_i ),
        .multiplier_i   ( multiplier_i   ),
        .product_o      ( product_o      ),
        .data_valid_o   ( data_valid_o   )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    // ----------------------------------------
    // Reference model and stimulus helpers
    // ----------------------------------------

    // Extend each operand as the ISA says and keep the right half of the 64-bit product
    function automatic mul_pkg::word_t model_product(input mul_pkg::mul_operation_t op,
                                                     input mul_pkg::word_t a,
                                                     input mul_pkg::word_t b);
        logic [63:0] a_ext;
        logic [63:0] b_ext;
        logic [63:0] full;
        a_ext = (op == mul_pkg::MULHU) ? {32'h0, a} : {{32{a[31]}}, a};
        b_ext = (op == mul_pkg::MUL || op == mul_pkg::MULH) ? {{32{b[31]}}, b} : {32'h0, b};
        full  = a_ext * b_ext;
        return (op == mul_pkg::MUL) ? full[31:0] : full[63:32];
    endfunction

    // Sign boundaries turn up about three times in eight
    function automatic mul_pkg::word_t random_operand();
        case ($urandom_range(0, 7))
            0: return 32'h8000_0000;
            1: return 32'h7fff_ffff;
            2: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    task automatic load_table();
        vector_table[ 0] = '{mul_pkg::MUL,    32'h0000_0000, 32'h0000_0000, 32'h0000_0000};
        vector_table[ 1] = '{mul_pkg::MUL,    32'h0000_0001, 32'hffff_ffff, 32'hffff_ffff};
        vector_table[ 2] = '{mul_pkg::MUL,    32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001};
        vector_table[ 3] = '{mul_pkg::MUL,    32'h8000_0000, 32'hffff_ffff, 32'h8000_0000};
        vector_table[ 4] = '{mul_pkg::MUL,    32'h7fff_ffff, 32'h7fff_ffff, 32'h0000_0001};
        vector_table[ 5] = '{mul_pkg::MUL,    32'h0000_0007, 32'hffff_fffd, 32'hffff_ffeb};
        vector_table[ 6] = '{mul_pkg::MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000};
        vector_table[ 7] = '{mul_pkg::MULH,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000};
        vector_table[ 8] = '{mul_pkg::MULH,   32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_ffff};
        vector_table[ 9] = '{mul_pkg::MULH,   32'h8000_0000, 32'h7fff_ffff, 32'hc000_0000};
        vector_table[10] = '{mul_pkg::MULH,   32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff};
        vector_table[11] = '{mul_pkg::MULH,   32'hffff_0000, 32'h0001_0000, 32'hffff_ffff};
        vector_table[12] = '{mul_pkg::MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff};
        vector_table[13] = '{mul_pkg::MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hc000_0000};
        vector_table[14] = '{mul_pkg::MULHSU, 32'h7fff_ffff, 32'hffff_ffff, 32'h7fff_fffe};
        vector_table[15] = '{mul_pkg::MULHSU, 32'hffff_fffe, 32'h8000_0000, 32'hffff_ffff};
        vector_table[16] = '{mul_pkg::MULHU,  32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe};
        vector_table[17] = '{mul_pkg::MULHU,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000};
        vector_table[18] = '{mul_pkg::MULHU,  32'h7fff_ffff, 32'h0000_0002, 32'h0000_0000};
        vector_table[19] = '{mul_pkg::MULHU,  32'h1234_5678, 32'h0000_0010, 32'h0000_0001};
    endtask

    // Freezes the pipe for stall_cycles, then presents one operand pair
    task automatic drive_vector(input vector_t vec, input int stall_cycles);
        pending_t entry;
        repeat (stall_cycles) begin
            @(negedge clk_i);
            clk_en_i       = 1'b0;
            // Junk on the operands must not leak in while frozen
            multiplicand_i = $urandom;
        end
        @(negedge clk_i);
        clk_en_i       = 1'b1;
        data_valid_i   = 1'b1;
        operation_i    = vec.operation;
        multiplicand_i = vec.multiplicand;
        multiplier_i   = vec.multiplier;
        entry.product  = vec.product;
        entry.edge_idx = enabled_edges + 1;
        pending.push_back(entry);
    endtask

    // ----------------------------------------
    // Result checking
    // ----------------------------------------

    always @(posedge clk_i) begin : edge_tracking
        last_edge_enabled <= rst_n_i && clk_en_i;
        if (rst_n_i && clk_en_i) begin
            enabled_edges <= enabled_edges + 1;
        end
    end : edge_tracking

    // Each valid result is compared with the oldest expected entry half a cycle after its edge
    always @(negedge clk_i) begin : result_check
        pending_t head;
        if (last_edge_enabled && data_valid_o) begin
            assert (pending.size() != 0)
                else stop_on_error("data_valid_o went high with no operation in flight");
            head = pending.pop_front();
            assert (product_o == head.product)
                else stop_on_error($sformatf("ERROR at %0t ns: product_o = 0x%08h, expected 0x%08h",
                                             $time, product_o, head.product));
            assert (enabled_edges - head.edge_idx + 1 == mul_pkg::MUL_LATENCY)
                else stop_on_error($sformatf("ERROR at %0t ns: latency = %0d, expected %0d",
                                             $time, enabled_edges - head.edge_idx + 1,
                                             mul_pkg::MUL_LATENCY));
        end else if (last_edge_enabled && pending.size() != 0) begin
            assert (enabled_edges - pending[0].edge_idx + 1 < mul_pkg::MUL_LATENCY)
                else stop_on_error("A result was due but data_valid_o stayed low");
        end
    end : result_check

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_on_error("Timeout, the run did not complete in the expected time");
    end : watchdog

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin : main_sequence
        vector_t vec;
        void'($urandom(32'hf0d07c90));
        rst_n_i        = 1'b0;
        clk_en_i       = 1'b1;
        data_valid_i   = 1'b0;
        operation_i    = mul_pkg::MUL;
        multiplicand_i = '0;
        multiplier_i   = '0;
        load_table();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;

        // Corner cases on every cycle, no stalls
        for (int i = 0; i < NUM_TABLE; i++) begin
            drive_vector(vector_table[i], 0);
        end

        // Random pairs with the enable dropped now and then
        for (int i = 0; i < NUM_RANDOM; i++) begin
            vec.operation    = mul_pkg::mul_operation_t'($urandom_range(0, 3));
            vec.multiplicand = random_operand();
            vec.multiplier   = random_operand();
            vec.product      = model_product(vec.operation, vec.multiplicand, vec.multiplier);
            drive_vector(vec, ($urandom_range(0, 3) == 0) ? $urandom_range(1, MAX_STALL) : 0);
        end

        @(negedge clk_i);
        data_valid_i = 1'b0;
        clk_en_i     = 1'b1;
        repeat (mul_pkg::MUL_LATENCY + 2) @(negedge clk_i);

        if (pending.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d results never came out of the pipeline",
                                    pending.size()));
        end
    end : main_sequence

endmodule : tb_multiplication_unit

`default_nettype wire
